/* rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN 32

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

// One quotient or product bit per iteration
`define MDU_CYCLES 32

`define LINK_INC   4
`define LINK_INC_C 2

`endif

/* rv_pkg.sv */
`include "rv_consts.svh"

package rv_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU,
        XOR, SRL, SRA, OR, AND
    } alu_op_e;

    typedef enum logic [1:0] {
        MUL, DIVU, REMU
    } mdu_op_e;

    typedef enum logic [1:0] {
        FWD_REG, FWD_EXMEM, FWD_MEMWB
    } fwd_sel_e;

    // ID to EX
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      instr;
        logic [`XLEN-1:0] rs1_data;
        logic [`XLEN-1:0] rs2_data;
        logic             compressed;
    } issue_t;

    typedef struct packed {
        logic             we;
        logic [4:0]       rd;
        logic [`XLEN-1:0] value;
    } bypass_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      instr;
        logic [`XLEN-1:0] result;   // ALU, link or MDU value
        logic [4:0]       rd;
        logic             we;
    } ex_out_t;

    typedef struct packed {
        logic             taken;
        logic [`XLEN-1:0] target;
    } redirect_t;

endpackage

/* imm_gen.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module imm_gen (
    input  logic [31:0]       instr_i,
    output logic [`XLEN-1:0]  imm_o
);

    always_comb begin
        case (instr_i[6:0])
            rv_pkg::OP_IMM, rv_pkg::LOAD, rv_pkg::JALR: begin
                imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            rv_pkg::STORE: begin
                imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            rv_pkg::BRANCH: begin
                imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
            end
            rv_pkg::LUI, rv_pkg::AUIPC: begin
                imm_o = {instr_i[31:12], 12'b0};
            end
            rv_pkg::JAL: begin
                imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            end
            default: imm_o = '0;   // R-type has no immediate
        endcase
    end

endmodule

/* alu_decode.sv */
`timescale 1ns/1ns

module alu_decode (
    input  logic [31:0]     instr_i,
    output rv_pkg::alu_op_e alu_op_o,
    output rv_pkg::mdu_op_e mdu_op_o,
    output logic            is_mdu_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;           // funct7 bit 5

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign alt    = instr_i[30];

    always_comb begin
        alu_op_o = rv_pkg::ADD;   // Loads, stores, LUI, AUIPC, jumps
        if (opcode == rv_pkg::OP || opcode == rv_pkg::OP_IMM) begin
            case (funct3)
                3'b000: alu_op_o = (alt && opcode == rv_pkg::OP) ? rv_pkg::SUB : rv_pkg::ADD;
                3'b001: alu_op_o = rv_pkg::SLL;
                3'b010: alu_op_o = rv_pkg::SLT;
                3'b011: alu_op_o = rv_pkg::SLTU;
                3'b100: alu_op_o = rv_pkg::XOR;
                3'b101: alu_op_o = alt ? rv_pkg::SRA : rv_pkg::SRL;
                3'b110: alu_op_o = rv_pkg::OR;
                default: alu_op_o = rv_pkg::AND;
            endcase
        end
    end

    always_comb begin
        case (funct3)
            3'b101:  mdu_op_o = rv_pkg::DIVU;
            3'b111:  mdu_op_o = rv_pkg::REMU;
            default: mdu_op_o = rv_pkg::MUL;
        endcase
    end

    assign is_mdu_o = (opcode == rv_pkg::OP) && (instr_i[31:25] == 7'b0000001);

endmodule

/* alu.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module alu (
    input  rv_pkg::alu_op_e  alu_op_i,
    input  logic [`XLEN-1:0] a_i,
    input  logic [`XLEN-1:0] b_i,
    output logic [`XLEN-1:0] result_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (alu_op_i)
            rv_pkg::ADD:  result_o = a_i + b_i;
            rv_pkg::SUB:  result_o = a_i - b_i;
            rv_pkg::SLL:  result_o = a_i << shamt;
            rv_pkg::SLT:  result_o = {{(`XLEN-1){1'b0}}, lt_signed};
            rv_pkg::SLTU: result_o = {{(`XLEN-1){1'b0}}, lt_unsigned};
            rv_pkg::XOR:  result_o = a_i ^ b_i;
            rv_pkg::SRL:  result_o = a_i >> shamt;
            rv_pkg::SRA:  result_o = $signed(a_i) >>> shamt;
            rv_pkg::OR:   result_o = a_i | b_i;
            rv_pkg::AND:  result_o = a_i & b_i;
            default:      result_o = '0;
        endcase
    end

endmodule

/* forward_unit.sv */
`timescale 1ns/1ns

module forward_unit (
    input  logic [4:0]       rs1_i,
    input  logic [4:0]       rs2_i,
    input  rv_pkg::bypass_t  ex_mem_i,
    input  rv_pkg::bypass_t  mem_wb_i,
    output rv_pkg::fwd_sel_e sel_a_o,
    output rv_pkg::fwd_sel_e sel_b_o
);

    // The younger EX/MEM value wins over MEM/WB
    function automatic rv_pkg::fwd_sel_e pick(input logic [4:0] rs,
                                              input rv_pkg::bypass_t ex_mem,
                                              input rv_pkg::bypass_t mem_wb);
        if (rs == 5'd0) begin
            pick = rv_pkg::FWD_REG;
        end else if (ex_mem.we && ex_mem.rd == rs) begin
            pick = rv_pkg::FWD_EXMEM;
        end else if (mem_wb.we && mem_wb.rd == rs) begin
            pick = rv_pkg::FWD_MEMWB;
        end else begin
            pick = rv_pkg::FWD_REG;
        end
    endfunction

    assign sel_a_o = pick(rs1_i, ex_mem_i, mem_wb_i);
    assign sel_b_o = pick(rs2_i, ex_mem_i, mem_wb_i);

endmodule

/* mdu.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module mdu (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             start_i,
    input  rv_pkg::mdu_op_e  op_i,
    input  logic [`XLEN-1:0] a_i,
    input  logic [`XLEN-1:0] b_i,
    output logic             busy_o,
    output logic [`XLEN-1:0] result_o
);

    logic [`XLEN-1:0] x_q;   // Product accumulator or remainder
    logic [`XLEN-1:0] y_q;   // Multiplicand or dividend/quotient
    logic [`XLEN-1:0] z_q;   // Multiplier or divisor
    rv_pkg::mdu_op_e  op_q;
    logic [$clog2(`MDU_CYCLES)-1:0] count_q;
    logic [3*`XLEN-1:0] first;
    logic [3*`XLEN-1:0] next;

    // One iteration, returns {x, y, z}
    function automatic logic [3*`XLEN-1:0] step(input rv_pkg::mdu_op_e op,
                                                input logic [`XLEN-1:0] x,
                                                input logic [`XLEN-1:0] y,
                                                input logic [`XLEN-1:0] z);
        logic [`XLEN:0] shifted;
        logic [`XLEN:0] diff;
        shifted = {x, y[`XLEN-1]};
        diff    = shifted - {1'b0, z};
        if (op == rv_pkg::MUL) begin
            step = {(z[0] ? x + y : x), y << 1, z >> 1};
        end else if (shifted >= {1'b0, z}) begin
            step = {diff[`XLEN-1:0], y[`XLEN-2:0], 1'b1, z};
        end else begin
            step = {shifted[`XLEN-1:0], y[`XLEN-2:0], 1'b0, z};
        end
    endfunction

    // The start edge already does the first iteration
    assign first = step(op_i, '0, a_i, b_i);
    assign next  = step(op_q, x_q, y_q, z_q);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_o  <= 1'b0;
            count_q <= '0;
        end else if (start_i) begin
            busy_o  <= 1'b1;
            count_q <= $bits(count_q)'(1);
        end else if (busy_o) begin
            count_q <= count_q + 1'b1;
            if (count_q == $bits(count_q)'(`MDU_CYCLES - 1)) begin
                busy_o <= 1'b0;   // Last iteration on this edge
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            op_q            <= op_i;
            {x_q, y_q, z_q} <= first;
        end else if (busy_o) begin
            {x_q, y_q, z_q} <= next;
        end
    end

    // Divide by zero falls out as all ones and the dividend
    assign result_o = (op_q == rv_pkg::DIVU) ? y_q : x_q;

endmodule

/* execute_stage.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module execute_stage (
    input  logic              clk,
    input  logic              reset_i,
    input  rv_pkg::issue_t    issue_i,
    input  logic              flush_i,
    input  logic              mem_stall_i,
    input  rv_pkg::bypass_t   ex_mem_i,
    input  rv_pkg::bypass_t   mem_wb_i,
    output rv_pkg::ex_out_t   ex_out_o,
    output rv_pkg::redirect_t redirect_o,
    output logic              stall_o
);

    rv_pkg::issue_t   ex_q;        // ID/EX register
    logic [`XLEN-1:0] imm_q;
    rv_pkg::alu_op_e  alu_op_q;
    rv_pkg::mdu_op_e  mdu_op_q;
    logic             is_mdu_q;
    logic             start_q;     // First cycle of an MDU op in EX

    logic [`XLEN-1:0] imm_d;
    rv_pkg::alu_op_e  alu_op_d;
    rv_pkg::mdu_op_e  mdu_op_d;
    logic             is_mdu_d;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [4:0]       rd;
    rv_pkg::fwd_sel_e sel_a;
    rv_pkg::fwd_sel_e sel_b;
    logic [`XLEN-1:0] fwd_a;
    logic [`XLEN-1:0] fwd_b;
    logic [`XLEN-1:0] alu_a;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] mdu_result;
    logic [`XLEN-1:0] link;
    logic [`XLEN-1:0] jalr_sum;
    logic             mdu_busy;
    logic             capture;
    logic             cond;
    logic             taken;

    function automatic logic [`XLEN-1:0] fwd_mux(input rv_pkg::fwd_sel_e sel,
                                                 input logic [`XLEN-1:0] reg_val,
                                                 input logic [`XLEN-1:0] ex_mem_val,
                                                 input logic [`XLEN-1:0] mem_wb_val);
        case (sel)
            rv_pkg::FWD_EXMEM: fwd_mux = ex_mem_val;
            rv_pkg::FWD_MEMWB: fwd_mux = mem_wb_val;
            default:           fwd_mux = reg_val;
        endcase
    endfunction

    imm_gen imm_gen_inst (
        .instr_i (issue_i.instr),
        .imm_o   (imm_d)
    );

    alu_decode alu_decode_inst (
        .instr_i  (issue_i.instr),
        .alu_op_o (alu_op_d),
        .mdu_op_o (mdu_op_d),
        .is_mdu_o (is_mdu_d)
    );

    assign capture = !stall_o && !mem_stall_i;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i || redirect_o.taken) begin
            ex_q     <= '{instr: `NOP_INSTR, default: '0};
            imm_q    <= '0;
            alu_op_q <= rv_pkg::ADD;
            is_mdu_q <= 1'b0;
            start_q  <= 1'b0;
        end else if (capture) begin
            ex_q     <= issue_i;
            imm_q    <= imm_d;
            alu_op_q <= alu_op_d;
            mdu_op_q <= mdu_op_d;
            is_mdu_q <= is_mdu_d;
            start_q  <= is_mdu_d;
        end else begin
            start_q  <= 1'b0;
        end
    end

    assign opcode = ex_q.instr[6:0];
    assign funct3 = ex_q.instr[14:12];
    assign rd     = ex_q.instr[11:7];

    forward_unit forward_unit_inst (
        .rs1_i    (ex_q.instr[19:15]),
        .rs2_i    (ex_q.instr[24:20]),
        .ex_mem_i (ex_mem_i),
        .mem_wb_i (mem_wb_i),
        .sel_a_o  (sel_a),
        .sel_b_o  (sel_b)
    );

    assign fwd_a = fwd_mux(sel_a, ex_q.rs1_data, ex_mem_i.value, mem_wb_i.value);
    assign fwd_b = fwd_mux(sel_b, ex_q.rs2_data, ex_mem_i.value, mem_wb_i.value);

    always_comb begin
        case (opcode)
            rv_pkg::AUIPC: alu_a = ex_q.pc;
            rv_pkg::LUI:   alu_a = '0;
            default:       alu_a = fwd_a;
        endcase
        case (opcode)
            rv_pkg::OP, rv_pkg::BRANCH: alu_b = fwd_b;
            default:                    alu_b = imm_q;
        endcase
    end

    alu alu_inst (
        .alu_op_i (alu_op_q),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    // Operands are latched on the edge that ends the start cycle
    mdu mdu_inst (
        .clk      (clk),
        .reset_i  (reset_i),
        .start_i  (start_q),
        .op_i     (mdu_op_q),
        .a_i      (fwd_a),
        .b_i      (fwd_b),
        .busy_o   (mdu_busy),
        .result_o (mdu_result)
    );

    assign stall_o = is_mdu_q && (start_q || mdu_busy);

    always_comb begin
        case (funct3)
            3'b000:  cond = fwd_a == fwd_b;
            3'b001:  cond = fwd_a != fwd_b;
            3'b100:  cond = $signed(fwd_a) < $signed(fwd_b);
            3'b101:  cond = $signed(fwd_a) >= $signed(fwd_b);
            3'b110:  cond = fwd_a < fwd_b;
            3'b111:  cond = fwd_a >= fwd_b;
            default: cond = 1'b0;
        endcase
        case (opcode)
            rv_pkg::BRANCH:            taken = cond;
            rv_pkg::JAL, rv_pkg::JALR: taken = 1'b1;
            default:                   taken = 1'b0;
        endcase
    end

    assign jalr_sum = fwd_a + imm_q;
    assign link     = ex_q.pc + (ex_q.compressed ? `LINK_INC_C : `LINK_INC);

    // Held back under a memory stall so the redirect fires once
    assign redirect_o.taken  = taken && !mem_stall_i;
    assign redirect_o.target = (opcode == rv_pkg::JALR) ? {jalr_sum[`XLEN-1:1], 1'b0}
                                                       : ex_q.pc + imm_q;

    always_comb begin
        ex_out_o.pc    = ex_q.pc;
        ex_out_o.instr = ex_q.instr;
        ex_out_o.rd    = rd;
        if (is_mdu_q) begin
            ex_out_o.result = mdu_result;
        end else if (opcode == rv_pkg::JAL || opcode == rv_pkg::JALR) begin
            ex_out_o.result = link;
        end else begin
            ex_out_o.result = alu_result;
        end
        // A NOP writes x0 and so stays quiet here too
        ex_out_o.we = (rd != 5'd0) && (opcode != rv_pkg::STORE) && (opcode != rv_pkg::BRANCH);
    end

endmodule

/* tb_execute_stage.sv */
`timescale 1ns/1ns
`include "rv_consts.svh"

module tb_execute_stage;

    localparam int NUM_TXN = 300;
    localparam int PERIOD  = 8;

    logic              clk = 1'b0;
    logic              reset_i;
    rv_pkg::issue_t    issue_i;
    logic              flush_i;
    logic              mem_stall_i;
    rv_pkg::bypass_t   ex_mem_i;
    rv_pkg::bypass_t   mem_wb_i;
    rv_pkg::ex_out_t   ex_out_o;
    rv_pkg::redirect_t redirect_o;
    logic              stall_o;

    integer seed       = 76839;
    int     value_errs = 0;
    int     other_errs = 0;
    int     captured   = 0;

    // Reference copy of the ID/EX register
    rv_pkg::issue_t m_ex;
    logic           m_mdu;
    logic           m_first;     // First cycle of an MDU op in EX
    logic           m_done;
    logic [31:0]    m_mdu_exp;
    int             m_wait;
    logic           m_taken;

    execute_stage execute_stage_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .issue_i     (issue_i),
        .flush_i     (flush_i),
        .mem_stall_i (mem_stall_i),
        .ex_mem_i    (ex_mem_i),
        .mem_wb_i    (mem_wb_i),
        .ex_out_o    (ex_out_o),
        .redirect_o  (redirect_o),
        .stall_o     (stall_o)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        value_errs++;
        $display("ERR t=%0t %s expected %h got %h", $time, name, exp_val, got_val);
    endtask

    task automatic report_failure(input string what);
        other_errs++;
        $display("Failure at t=%0t: %s", $time, what);
    endtask

    function automatic logic [31:0] imm_of(input logic [31:0] instr);
        case (instr[6:0])
            rv_pkg::STORE:  imm_of = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_pkg::BRANCH: imm_of = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            rv_pkg::LUI, rv_pkg::AUIPC: imm_of = {instr[31:12], 12'h000};
            rv_pkg::JAL:    imm_of = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:        imm_of = {{20{instr[31]}}, instr[31:20]};   // I-type
        endcase
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: alu_ref = alt ? a - b : a + b;
            3'd1: alu_ref = a << b[4:0];
            3'd2: alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: alu_ref = (a < b) ? 32'd1 : 32'd0;
            3'd4: alu_ref = a ^ b;
            3'd5: begin
                if (alt) begin
                    alu_ref = $signed(a) >>> b[4:0];
                end else begin
                    alu_ref = a >> b[4:0];
                end
            end
            3'd6: alu_ref = a | b;
            default: alu_ref = a & b;
        endcase
    endfunction

    function automatic logic [31:0] mdu_ref(input logic [2:0] f3, input logic [31:0] a,
                                            input logic [31:0] b);
        if (f3 == 3'b101) begin
            if (b == 32'd0) mdu_ref = 32'hFFFF_FFFF;
            else mdu_ref = a / b;
        end else if (f3 == 3'b111) begin
            if (b == 32'd0) mdu_ref = a;
            else mdu_ref = a % b;
        end else begin
            mdu_ref = a * b;
        end
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0: branch_taken = a == b;
            3'd1: branch_taken = a != b;
            3'd4: branch_taken = $signed(a) < $signed(b);
            3'd5: branch_taken = $signed(a) >= $signed(b);
            3'd6: branch_taken = a < b;
            3'd7: branch_taken = a >= b;
            default: branch_taken = 1'b0;
        endcase
    endfunction

    // EX/MEM wins over MEM/WB and x0 never forwards
    function automatic logic [31:0] fwd_value(input logic [4:0] rs, input logic [31:0] reg_val);
        if (rs == 5'd0) fwd_value = reg_val;
        else if (ex_mem_i.we && ex_mem_i.rd == rs) fwd_value = ex_mem_i.value;
        else if (mem_wb_i.we && mem_wb_i.rd == rs) fwd_value = mem_wb_i.value;
        else fwd_value = reg_val;
    endfunction

    task automatic draw_word(output logic [31:0] w);
        if ({$random(seed)} % 2 == 0) begin
            w = 32'({$random(seed)} % 4);   // Small values make equal compares likely
        end else begin
            w = $random(seed);
        end
    endtask

    task automatic draw_instr(output logic [31:0] instr);
        int         kind;
        logic [2:0] f3;
        logic       alt;
        instr        = $random(seed);
        kind         = {$random(seed)} % 16;
        instr[11:7]  = 5'({$random(seed)} % 4);   // Few registers so bypasses hit often
        instr[19:15] = 5'({$random(seed)} % 4);
        instr[24:20] = 5'({$random(seed)} % 4);
        f3           = instr[14:12];
        alt          = instr[30];
        if (kind < 3) begin
            instr[6:0]   = rv_pkg::OP;
            instr[31:25] = (alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0000000;
        end else if (kind < 6) begin
            instr[6:0] = rv_pkg::OP_IMM;
            if (f3 == 3'd1 || f3 == 3'd5) begin
                instr[31:25] = (alt && f3 == 3'd5) ? 7'b0100000 : 7'b0000000;
            end
        end else if (kind == 6) begin
            instr[6:0] = rv_pkg::LUI;
        end else if (kind == 7) begin
            instr[6:0] = rv_pkg::AUIPC;
        end else if (kind < 10) begin
            instr[6:0] = rv_pkg::BRANCH;
            if (f3 == 3'd2 || f3 == 3'd3) begin
                instr[14:12] = 3'd0;
            end
        end else if (kind == 10) begin
            instr[6:0] = rv_pkg::JAL;
        end else if (kind == 11) begin
            instr[6:0]   = rv_pkg::JALR;
            instr[14:12] = 3'd0;
        end else if (kind < 14) begin
            instr[6:0]   = (kind == 12) ? rv_pkg::LOAD : rv_pkg::STORE;
            instr[14:12] = 3'd2;
        end else begin
            instr[6:0]   = rv_pkg::OP;
            instr[31:25] = 7'b0000001;
            case ({$random(seed)} % 3)
                0: instr[14:12] = 3'b000;      // MUL
                1: instr[14:12] = 3'b101;      // DIVU
                default: instr[14:12] = 3'b111;   // REMU
            endcase
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] instr;
        logic [31:0] d1;
        logic [31:0] d2;
        logic [31:0] v1;
        logic [31:0] v2;
        draw_instr(instr);
        draw_word(d1);
        draw_word(d2);
        draw_word(v1);
        draw_word(v2);
        if (instr[19:15] == 5'd0) d1 = '0;   // Register file reads x0 as zero
        if (instr[24:20] == 5'd0) d2 = '0;
        issue_i.pc         <= $random(seed) & 32'hFFFF_FFFE;
        issue_i.instr      <= instr;
        issue_i.rs1_data   <= d1;
        issue_i.rs2_data   <= d2;
        issue_i.compressed <= ({$random(seed)} % 2 == 1);
        ex_mem_i.we        <= ({$random(seed)} % 3 != 0);
        ex_mem_i.rd        <= 5'({$random(seed)} % 4);
        ex_mem_i.value     <= v1;
        mem_wb_i.we        <= ({$random(seed)} % 3 != 0);
        mem_wb_i.rd        <= 5'({$random(seed)} % 4);
        mem_wb_i.value     <= v2;
        mem_stall_i        <= ({$random(seed)} % 6 == 0);
        flush_i            <= ({$random(seed)} % 24 == 0);
    endtask

    task automatic check_after_reset();
        assert (stall_o == 1'b0) else report_failure("stall_o is high after reset");
        assert (redirect_o.taken == 1'b0) else report_failure("redirect is taken after reset");
        assert (ex_out_o.we == 1'b0) else report_failure("ex_out_o.we is high after reset");
        assert (ex_out_o.instr == `NOP_INSTR)
            else report_mismatch("ex_out_o.instr", `NOP_INSTR, ex_out_o.instr);
    endtask

    task automatic check_outputs();
        logic [6:0]  opc;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] link;
        logic [31:0] exp_res;
        logic [31:0] exp_target;
        logic        exp_we;
        opc        = m_ex.instr[6:0];
        rd         = m_ex.instr[11:7];
        f3         = m_ex.instr[14:12];
        a          = fwd_value(m_ex.instr[19:15], m_ex.rs1_data);
        b          = fwd_value(m_ex.instr[24:20], m_ex.rs2_data);
        imm        = imm_of(m_ex.instr);
        link       = m_ex.pc + (m_ex.compressed ? `LINK_INC_C : `LINK_INC);
        exp_we     = rd != 5'd0 && opc != rv_pkg::STORE && opc != rv_pkg::BRANCH;
        exp_target = m_ex.pc + imm;
        m_taken    = 1'b0;
        case (opc)
            rv_pkg::OP:     exp_res = alu_ref(f3, m_ex.instr[30], a, b);
            rv_pkg::OP_IMM: exp_res = alu_ref(f3, f3 == 3'd5 && m_ex.instr[30], a, imm);
            rv_pkg::LUI:    exp_res = imm;
            rv_pkg::AUIPC:  exp_res = m_ex.pc + imm;
            rv_pkg::BRANCH: begin
                m_taken = branch_taken(f3, a, b);
            end
            rv_pkg::JAL: begin
                exp_res = link;
                m_taken = 1'b1;
            end
            rv_pkg::JALR: begin
                exp_res    = link;
                m_taken    = 1'b1;
                exp_target = (a + imm) & 32'hFFFF_FFFE;
            end
            default: exp_res = a + imm;   // Load and store address
        endcase
        m_taken = m_taken && !mem_stall_i;

        assert (ex_out_o.instr == m_ex.instr)
            else report_mismatch("ex_out_o.instr", m_ex.instr, ex_out_o.instr);
        assert (ex_out_o.pc == m_ex.pc) else report_mismatch("ex_out_o.pc", m_ex.pc, ex_out_o.pc);
        assert (ex_out_o.rd == rd) else report_mismatch("ex_out_o.rd", 32'(rd), 32'(ex_out_o.rd));
        assert (ex_out_o.we == exp_we)
            else report_mismatch("ex_out_o.we", 32'(exp_we), 32'(ex_out_o.we));
        assert (redirect_o.taken == m_taken)
            else report_mismatch("redirect_o.taken", 32'(m_taken), 32'(redirect_o.taken));
        if (m_taken) begin
            assert (redirect_o.target == exp_target)
                else report_mismatch("redirect_o.target", exp_target, redirect_o.target);
        end

        if (m_mdu && !m_done) begin
            if (m_first) begin
                m_first   = 1'b0;
                m_mdu_exp = mdu_ref(f3, a, b);   // Operands as forwarded in the start cycle
                assert (stall_o) else begin
                    report_failure("stall_o did not rise for an MDU instruction");
                    m_done = 1'b1;
                end
            end else if (stall_o) begin
                m_wait++;
                assert (m_wait != `MDU_CYCLES)
                    else report_failure("stall_o stayed high past the MDU iteration count");
            end else begin
                m_done = 1'b1;
                // The start cycle adds one to the counted stall cycles
                assert (m_wait + 1 == `MDU_CYCLES)
                    else report_mismatch("stall_o high cycles", 32'(`MDU_CYCLES),
                                         32'(m_wait + 1));
            end
        end
        if (m_mdu && m_done) begin
            assert (ex_out_o.result == m_mdu_exp)
                else report_mismatch("ex_out_o.result", m_mdu_exp, ex_out_o.result);
        end else if (!m_mdu) begin
            assert (stall_o == 1'b0) else report_failure("stall_o is high without an MDU op");
            if (opc != rv_pkg::BRANCH) begin
                assert (ex_out_o.result == exp_res)
                    else report_mismatch("ex_out_o.result", exp_res, ex_out_o.result);
            end
        end
    endtask

    // Next state of the reference register from the inputs held since the last edge
    task automatic update_model();
        if (flush_i || m_taken) begin
            m_ex       = '0;
            m_ex.instr = `NOP_INSTR;
            m_mdu      = 1'b0;
        end else if (!(m_mdu && !m_done) && !mem_stall_i) begin
            m_ex    = issue_i;
            m_mdu   = issue_i.instr[6:0] == rv_pkg::OP && issue_i.instr[31:25] == 7'b0000001;
            m_first = m_mdu;
            m_done  = 1'b0;
            m_wait  = 0;
            captured++;
        end
    endtask

    initial begin
        reset_i     = 1'b1;
        flush_i     = 1'b0;
        mem_stall_i = 1'b0;
        issue_i     = '0;
        issue_i.instr = `NOP_INSTR;
        ex_mem_i    = '0;
        mem_wb_i    = '0;
        m_ex        = '0;
        m_ex.instr  = `NOP_INSTR;
        m_mdu       = 1'b0;
        m_first     = 1'b0;
        m_done      = 1'b0;
        m_wait      = 0;
        m_taken     = 1'b0;
        m_mdu_exp   = '0;

        repeat (10) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check_after_reset();

        while (captured < NUM_TXN) begin
            check_outputs();
            update_model();
            @(posedge clk);
            drive_inputs();
            @(negedge clk);
        end

        $display("Done: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Every capture may cost a full MDU run
    initial begin
        #((NUM_TXN * (`MDU_CYCLES + 4) + 20) * PERIOD);
        $display("Timeout: the run did not finish in the expected number of cycles");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* sim.f */
+incdir+.
rv_pkg.sv
imm_gen.sv
alu_decode.sv
alu.sv
forward_unit.sv
mdu.sv
execute_stage.sv
tb_execute_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_execute_stage -f sim.f -o tb_execute_stage > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_execute_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0
